// File: project.f
logic/sseg_pkg.sv
logic/rate_divider.sv
logic/banner_rotator.sv
logic/digit_scanner.sv
logic/sseg_banner_top.sv
testbench/tb_sseg_banner.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_sseg_banner
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := TB PASSED

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_sseg_banner.sv
// ####################################################################
// Small divider values keep scroll and scan periods short in simulation
// Offsets are found from whole frames, so the fixed message needs
// ten distinct glyphs
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_sseg_banner
    import sseg_pkg::*;
();

    localparam int unsigned ROT_DIV  = 64;
    localparam int unsigned SCAN_DIV = 4;
    // Digits 0 to 9, active low, glyph 0 first
    localparam msg_t DIGITS_MSG = msg_t'(80'hC0F9A4B0999282F88090);
    localparam int DIGIT_TIMEOUT = 2 * NUM_DIGITS * SCAN_DIV;
    localparam int SETTLE_TRIES  = 8;
    localparam int STEP_COUNT    = 12;
    // Enough frame reads to cover four rotation periods
    localparam int PAUSE_READS   = (4 * ROT_DIV) / (2 * NUM_DIGITS * SCAN_DIV);

    logic       i_clk;
    logic       i_rst;
    logic       i_en;
    logic       i_dir;
    msg_t       i_msg;
    logic [3:0] o_ldsel;
    glyph_t     o_sseg_n;

    // Message the DUT currently shows
    msg_t        cur_msg;
    logic [15:0] lfsr_state;
    int          cur_ofs;

    sseg_banner_top #(
        .ROT_DIV (ROT_DIV),
        .SCAN_DIV(SCAN_DIV)
    ) dut0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_en    (i_en),
        .i_dir   (i_dir),
        .i_msg   (i_msg),
        .o_ldsel (o_ldsel),
        .o_sseg_n(o_sseg_n)
    );

    // 40 ns period
    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
            abort_run("value check failed");
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per glyph bit
    task automatic random_glyph(output glyph_t g);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[6:0], lfsr_state[0]};
        end
        g = glyph_t'(bits);
    endtask

    // Digit k shows message glyph (offset + k) mod MSG_LEN
    function automatic window_t expected_window(input msg_t m, input int ofs);
        window_t w;
        w.digit0 = m[(ofs + 0) % MSG_LEN];
        w.digit1 = m[(ofs + 1) % MSG_LEN];
        w.digit2 = m[(ofs + 2) % MSG_LEN];
        w.digit3 = m[(ofs + 3) % MSG_LEN];
        return w;
    endfunction

    // Lowest matching rotation, -1 when none fits
    function automatic int find_offset(input msg_t m, input window_t w);
        int found;
        found = -1;
        for (int o = MSG_LEN - 1; o >= 0; o--) begin
            if (expected_window(m, o) == w) begin
                found = o;
            end
        end
        return found;
    endfunction

    // Segments seen on the first cycle of one digit select
    task automatic wait_digit(input logic [3:0] sel, output glyph_t g);
        int n;
        n = 0;
        @(negedge i_clk);
        while (o_ldsel !== sel) begin
            n++;
            if (n > DIGIT_TIMEOUT) begin
                abort_run("digit select never reached the expected digit");
            end
            @(negedge i_clk);
        end
        g = o_sseg_n;
    endtask

    task automatic read_frame(output window_t w);
        glyph_t g0;
        glyph_t g1;
        glyph_t g2;
        glyph_t g3;
        wait_digit(4'b0001, g0);
        wait_digit(4'b0010, g1);
        wait_digit(4'b0100, g2);
        wait_digit(4'b1000, g3);
        w.digit0 = g0;
        w.digit1 = g1;
        w.digit2 = g2;
        w.digit3 = g3;
    endtask

    // Two equal frames in a row, so no step fell inside the frame
    task automatic read_stable_frame(output window_t w, output int ofs);
        window_t prev;
        window_t cur;
        int      tries;
        tries = 0;
        read_frame(prev);
        read_frame(cur);
        while (cur !== prev) begin
            tries++;
            if (tries > SETTLE_TRIES) begin
                abort_run("displayed frames never settled");
            end
            prev = cur;
            read_frame(cur);
        end
        w = cur;
        ofs = find_offset(cur_msg, cur);
        if (ofs < 0) begin
            abort_run("displayed frame matches no rotation of the message");
        end
    endtask

    // Stop scrolling and read the held offset
    task automatic pause_scroll(input int last, input int delta, output int held);
        window_t w;
        int      ofs;
        @(posedge i_clk);
        i_en <= 1'b0;
        read_stable_frame(w, ofs);
        // A step may land between the last frame and the pause
        if (ofs != last) begin
            check_equal("offset at pause", ofs, (last + delta + MSG_LEN) % MSG_LEN);
        end
        held = ofs;
    endtask

    // Follow STEP_COUNT distinct offsets, scroll left enabled
    task automatic scroll_steps(input logic dir, input int delta);
        window_t w;
        int      ofs;
        int      last;
        int      steps;
        int      reads;
        @(posedge i_clk);
        i_dir <= dir;
        i_en  <= 1'b1;
        last = cur_ofs;
        steps = 0;
        reads = 0;
        while (steps < STEP_COUNT) begin
            reads++;
            if (reads > 6 * STEP_COUNT) begin
                abort_run("banner stopped scrolling");
            end
            read_stable_frame(w, ofs);
            if (ofs != last) begin
                check_equal("scroll offset", ofs, (last + delta + MSG_LEN) % MSG_LEN);
                last = ofs;
                steps++;
            end
        end
        cur_ofs = last;
    endtask

    task automatic test_reset();
        logic [3:0] prev;
        int         visits;
        int         n;
        @(posedge i_clk);
        repeat (4) begin
            @(negedge i_clk);
            check_equal("o_ldsel in reset", o_ldsel, 4'b0000);
            check_equal("o_sseg_n in reset", o_sseg_n, BLANK_GLYPH);
            @(posedge i_clk);
        end
        i_rst <= 1'b0;
        @(posedge i_clk);
        @(negedge i_clk);
        check_equal("o_ldsel after reset", o_ldsel, 4'b0001);
        prev = o_ldsel;
        visits = 1;
        n = 0;
        // Order 0, 1, 2, 3, 0 and one-hot every cycle
        while (visits < 5) begin
            n++;
            if (n > DIGIT_TIMEOUT * NUM_DIGITS) begin
                abort_run("digit select stopped cycling after reset");
            end
            @(negedge i_clk);
            check_equal("o_ldsel ones", $countones(o_ldsel), 1);
            if (o_ldsel != prev) begin
                check_equal("o_ldsel next digit", o_ldsel, {prev[2:0], prev[3]});
                prev = o_ldsel;
                visits++;
            end
        end
    endtask

    task automatic test_static();
        window_t w;
        int      ofs;
        repeat (3) begin
            read_stable_frame(w, ofs);
            check_equal("static offset", ofs, 0);
        end
    endtask

    task automatic test_pause();
        window_t w;
        int      ofs;
        int      held;
        pause_scroll(cur_ofs, -1, held);
        for (int i = 0; i < PAUSE_READS; i++) begin
            read_stable_frame(w, ofs);
            check_equal("paused offset", ofs, held);
        end
        cur_ofs = held;
    endtask

    task automatic test_msg_change();
        msg_t    new_msg;
        glyph_t  g;
        window_t w;
        int      ofs;
        for (int i = 0; i < MSG_LEN; i++) begin
            random_glyph(g);
            new_msg[i] = g;
        end
        @(posedge i_clk);
        i_msg <= new_msg;
        cur_msg = new_msg;
        // One full scan before looking
        read_frame(w);
        // Frame must be a rotation of the new message at the held offset
        read_stable_frame(w, ofs);
        check_equal("offset after message change", ofs, cur_ofs);
    endtask

    initial begin
        i_rst = 1'b1;
        i_en = 1'b0;
        i_dir = 1'b0;
        i_msg = DIGITS_MSG;
        cur_msg = DIGITS_MSG;
        lfsr_state = 16'd34759;
        cur_ofs = 0;
        test_reset();
        test_static();
        // Forward, then hold before turning around
        scroll_steps(1'b0, 1);
        pause_scroll(cur_ofs, 1, cur_ofs);
        scroll_steps(1'b1, -1);
        test_pause();
        test_msg_change();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/sseg_banner_top.sv
// ##################################################################
// Divider values are in clock cycles, set them for the board clock
// i_msg is a level, changes reach o_sseg_n two cycles later
// Inputs are not debounced or synchronized here
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module sseg_banner_top
    import sseg_pkg::*;
#(
    parameter int unsigned ROT_DIV  = 50_000_000,
    parameter int unsigned SCAN_DIV = 100_000
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_en,
    input  logic       i_dir,
    input  msg_t       i_msg,
    output logic [3:0] o_ldsel,
    output glyph_t     o_sseg_n
);

    logic    w_step;
    logic    w_scan;
    window_t w_window;

    // Scroll rate, paused while i_en is low
    rate_divider #(
        .DIV(ROT_DIV)
    ) rot_div (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_en  (i_en),
        .o_tick(w_step)
    );

    // Digit refresh rate, always running
    rate_divider #(
        .DIV(SCAN_DIV)
    ) scan_div (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_en  (1'b1),
        .o_tick(w_scan)
    );

    // Offset and visible window
    banner_rotator u_banner_rotator (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_step  (w_step),
        .i_dir   (i_dir),
        .i_msg   (i_msg),
        .o_window(w_window)
    );

    // Multiplex onto shared segment lines
    digit_scanner u_digit_scanner (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_scan  (w_scan),
        .i_window(w_window),
        .o_ldsel (o_ldsel),
        .o_sseg_n(o_sseg_n)
    );

endmodule

`default_nettype wire

// File: logic/digit_scanner.sv
// ##################################################################
// Index advances on i_scan, outputs follow it one cycle later
// o_ldsel is active high, o_sseg_n keeps the active-low glyph
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module digit_scanner
    import sseg_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_scan,
    input  window_t    i_window,
    output logic [3:0] o_ldsel,
    output glyph_t     o_sseg_n
);

    localparam int IDX_W = $clog2(NUM_DIGITS);

    logic [IDX_W-1:0] r_idx;
    glyph_t           w_glyph;

    // Digit under the current index
    always_comb begin
        case (r_idx)
            2'd0: w_glyph = i_window.digit0;
            2'd1: w_glyph = i_window.digit1;
            2'd2: w_glyph = i_window.digit2;
            default: w_glyph = i_window.digit3;
        endcase
    end

    // Scan index 0 to 3 then back to 0
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_idx <= '0;
        end else if (i_scan) begin
            if (r_idx == IDX_W'(NUM_DIGITS - 1)) begin
                r_idx <= '0;
            end else begin
                r_idx <= r_idx + 1'b1;
            end
        end
    end

    // Select and segments registered together so they never skew
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ldsel  <= '0;
            o_sseg_n <= BLANK_GLYPH;
        end else begin
            o_ldsel  <= 4'b0001 << r_idx;
            o_sseg_n <= w_glyph;
        end
    end

    // Exactly one digit lit once the first index is registered
    a_ldsel_onehot : assert property (@(posedge i_clk) disable iff (i_rst)
        !$past(i_rst) |-> $onehot(o_ldsel))
        else $error("digit_scanner select not one-hot");

    // No scan step, so the select two cycles on stays put
    a_ldsel_hold : assert property (@(posedge i_clk) disable iff (i_rst)
        (!i_scan && !i_rst) |-> ##2 $stable(o_ldsel))
        else $error("digit_scanner select moved without a scan step");

endmodule

`default_nettype wire

// File: logic/banner_rotator.sv
// ##################################################################
// Offset steps once per i_step, i_dir 1 scrolls in reverse
// Window is registered every cycle, one cycle behind offset or message
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module banner_rotator
    import sseg_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_step,
    input  logic    i_dir,
    input  msg_t    i_msg,
    output window_t o_window
);

    // Enough bits to index any message glyph
    localparam int OFS_W = $clog2(MSG_LEN);

    logic [OFS_W-1:0] r_offset;
    logic [OFS_W-1:0] w_offset_nxt;
    window_t          w_window;

    // Message glyph at offset plus k, wrapped once
    // Largest sum stays below twice MSG_LEN
    function automatic glyph_t glyph_at(
        input msg_t             msg,
        input logic [OFS_W-1:0] ofs,
        input int unsigned      k
    );
        int unsigned idx;
        idx = int'(ofs) + k;
        if (idx >= MSG_LEN) begin
            idx = idx - MSG_LEN;
        end
        return msg[idx];
    endfunction

    // Next offset with wraparound in either direction
    always_comb begin
        w_offset_nxt = r_offset;
        if (i_step) begin
            if (!i_dir) begin
                // Forward
                if (r_offset == OFS_W'(MSG_LEN - 1)) begin
                    w_offset_nxt = '0;
                end else begin
                    w_offset_nxt = r_offset + 1'b1;
                end
            end else begin
                // Reverse
                if (r_offset == '0) begin
                    w_offset_nxt = OFS_W'(MSG_LEN - 1);
                end else begin
                    w_offset_nxt = r_offset - 1'b1;
                end
            end
        end
    end

    // Four consecutive glyphs from the current offset
    always_comb begin
        w_window.digit0 = glyph_at(i_msg, r_offset, 0);
        w_window.digit1 = glyph_at(i_msg, r_offset, 1);
        w_window.digit2 = glyph_at(i_msg, r_offset, 2);
        w_window.digit3 = glyph_at(i_msg, r_offset, 3);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_offset <= '0;
            // Dark socket until the first window is formed
            o_window <= '{BLANK_GLYPH, BLANK_GLYPH, BLANK_GLYPH, BLANK_GLYPH};
        end else begin
            r_offset <= w_offset_nxt;
            o_window <= w_window;
        end
    end

    // Offset stays a valid glyph index across every step and wrap
    a_offset_range : assert property (@(posedge i_clk) disable iff (i_rst)
        r_offset < OFS_W'(MSG_LEN))
        else $error("banner_rotator offset out of range");

endmodule

`default_nettype wire

// File: logic/rate_divider.sv
// ##################################################################
// Count only advances on cycles with i_en high
// o_tick is combinational and lasts one cycle per DIV enabled cycles
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module rate_divider #(
    parameter int unsigned DIV = 4
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_en,
    output logic o_tick
);

    // At least one bit even for DIV of 1
    localparam int unsigned CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] r_count;
    logic             w_last;

    // End of period
    assign w_last = (r_count == LAST);

    // Strobe only when the final count is also enabled
    assign o_tick = i_en && w_last;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_count <= '0;
        end else if (i_en) begin
            // Wrap back to zero after the strobe
            if (w_last) begin
                r_count <= '0;
            end else begin
                r_count <= r_count + 1'b1;
            end
        end
    end

    // Strobe never stretches past one cycle
    if (DIV > 1) begin : g_tick_chk
        a_tick_single : assert property (@(posedge i_clk) disable iff (i_rst)
            o_tick |=> !o_tick)
            else $error("rate_divider tick held for two cycles");
    end

endmodule

`default_nettype wire

// File: logic/sseg_pkg.sv
// ##################################################################
// Segment patterns are active low, so a zero bit lights a segment
// Field order puts dp in the MSB and segment a in the LSB
// Message and window hold glyph 0 and digit0 in their MSB
// ##################################################################
`default_nettype none

package sseg_pkg;

    // Glyph count in the scrolling message
    localparam int MSG_LEN = 10;

    // Digits on the LED socket
    localparam int NUM_DIGITS = 4;

    // One digit, active low
    typedef struct packed {
        logic dp;
        logic g;
        logic f;
        logic e;
        logic d;
        logic c;
        logic b;
        logic a;
    } glyph_t;

    // Whole banner message
    // Glyph 0 sits first in a concatenation
    typedef glyph_t [0:MSG_LEN-1] msg_t;

    // Four visible glyphs, leftmost digit first
    typedef struct packed {
        glyph_t digit0;
        glyph_t digit1;
        glyph_t digit2;
        glyph_t digit3;
    } window_t;

    // All segments dark
    localparam glyph_t BLANK_GLYPH = '1;

endpackage

`default_nettype wire
